// File: addr_decode.sv
// Address decode stage
// Classifies a request as ROM, SRAM or error and registers the result
`timescale 1ns/10ps
`default_nettype none

module addr_decode (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  input  wire                                   in_valid_i,
  output logic                                  in_ready_o,
  input  wire                                   in_we_i,
  input  wire mem_fabric_pkg::addr_u            in_addr_i,
  input  wire [mem_fabric_pkg::DataWidth-1:0]   in_wdata_i,
  input  wire [mem_fabric_pkg::StrbWidth-1:0]   in_strb_i,
  input  wire [mem_fabric_pkg::IdWidth-1:0]     in_id_i,
  output logic                                  out_valid_o,
  input  wire                                   out_ready_i,
  output mem_fabric_pkg::target_e               out_target_o,
  output logic [mem_fabric_pkg::IndexWidth-1:0] out_index_o,
  output logic                                  out_we_o,
  output logic [mem_fabric_pkg::DataWidth-1:0]  out_wdata_o,
  output logic [mem_fabric_pkg::StrbWidth-1:0]  out_strb_o,
  output logic [mem_fabric_pkg::IdWidth-1:0]    out_id_o
);

  mem_fabric_pkg::target_e target_d;
  logic                    fire;

  assign in_ready_o = !out_valid_o || out_ready_i;
  assign fire       = in_valid_i && in_ready_o;

  // ----------------------------------------------------------------------
  // Region match and bounds check
  // ----------------------------------------------------------------------
  always_comb begin
    target_d = mem_fabric_pkg::TgtErr;
    case (in_addr_i.region.tag)
      mem_fabric_pkg::RomBase: begin
        // Read-only, writes turn into errors
        if (!in_we_i && (in_addr_i.region.word < mem_fabric_pkg::RomWords)) begin
          target_d = mem_fabric_pkg::TgtRom;
        end
      end
      mem_fabric_pkg::SramBase: begin
        if (in_addr_i.region.word < mem_fabric_pkg::SramWords) begin
          target_d = mem_fabric_pkg::TgtSram;
        end
      end
      // Unmapped regions and the reserved GPIO window
      default: target_d = mem_fabric_pkg::TgtErr;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  // Result travels with the request fields
  always_ff @(posedge clk_i) begin
    if (fire) begin
      out_target_o <= target_d;
      out_index_o  <= in_addr_i.region.word[mem_fabric_pkg::IndexWidth-1:0];
      out_we_o     <= in_we_i;
      out_wdata_o  <= in_wdata_i;
      out_strb_o   <= in_strb_i;
      out_id_o     <= in_id_i;
    end
  end

endmodule

`default_nettype wire

// File: build.f
mem_fabric_pkg.sv
req_buffer.sv
addr_decode.sv
target_access.sv
rsp_sender.sv
mem_fabric_top.sv
tb_mem_fabric_sva.sv
tb_mem_fabric.sv

// File: mem_fabric_pkg.sv
// Shared definitions for the memory fabric
// Bus widths, address map, credit and FIFO sizes,
// boot ROM pattern, target enumeration and address union
`default_nettype none

package mem_fabric_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned IdWidth   = 4;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  // Region tag is the upper half-word of the byte address
  localparam logic [15:0] RomBase  = 16'h0001;
  localparam logic [15:0] GpioBase = 16'h0002;
  localparam logic [15:0] SramBase = 16'h8000;

  localparam int unsigned RomWords    = 32;
  localparam int unsigned SramWords   = 512;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);
  localparam int unsigned IndexWidth  = $clog2(SramWords);

  // ROM word k reads as this pattern plus k
  localparam logic [DataWidth-1:0] RomPattern = 64'hB007_C0DE_0000_0000;

  // ----------------------------------------------------------------------
  // Flow control
  // ----------------------------------------------------------------------
  localparam int unsigned ReqCredits  = 4;
  localparam int unsigned RspCredits  = 2;
  localparam int unsigned RspDepth    = 4;
  localparam int unsigned ReqPtrWidth = $clog2(ReqCredits);
  localparam int unsigned ReqCntWidth = $clog2(ReqCredits + 1);
  localparam int unsigned RspPtrWidth = $clog2(RspDepth);
  localparam int unsigned RspCntWidth = $clog2(RspDepth + 1);
  localparam int unsigned CreditWidth = $clog2(RspCredits + 1);

  // Decoded destination of a request
  typedef enum logic [1:0] {
    TgtRom,
    TgtSram,
    TgtErr
  } target_e;

  // Byte address, seen raw or as region tag plus offset
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      logic [15:0] tag;
      logic [12:0] word;
      logic [2:0]  lane;
    } region;
  } addr_u;

endpackage

`default_nettype wire

// File: mem_fabric_top.sv
// Memory fabric top level
// Entry FIFO, address decode, target access and response sender in a chain
`timescale 1ns/10ps
`default_nettype none

module mem_fabric_top (
  input  wire                                  clk_i,
  input  wire                                  rst_ni,
  input  wire                                  req_valid_i,
  input  wire                                  req_we_i,
  input  wire mem_fabric_pkg::addr_u           req_addr_i,
  input  wire [mem_fabric_pkg::DataWidth-1:0]  req_wdata_i,
  input  wire [mem_fabric_pkg::StrbWidth-1:0]  req_strb_i,
  input  wire [mem_fabric_pkg::IdWidth-1:0]    req_id_i,
  output logic                                 req_credit_o,
  input  wire                                  rsp_credit_i,
  output logic                                 rsp_valid_o,
  output logic [mem_fabric_pkg::IdWidth-1:0]   rsp_id_o,
  output logic [mem_fabric_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                                 rsp_err_o
);

  // Entry FIFO to decode
  logic                                 rb_valid;
  logic                                 rb_ready;
  logic                                 rb_we;
  mem_fabric_pkg::addr_u                rb_addr;
  logic [mem_fabric_pkg::DataWidth-1:0] rb_wdata;
  logic [mem_fabric_pkg::StrbWidth-1:0] rb_strb;
  logic [mem_fabric_pkg::IdWidth-1:0]   rb_id;

  // Decode to access
  logic                                  ad_valid;
  logic                                  ad_ready;
  mem_fabric_pkg::target_e               ad_target;
  logic [mem_fabric_pkg::IndexWidth-1:0] ad_index;
  logic                                  ad_we;
  logic [mem_fabric_pkg::DataWidth-1:0]  ad_wdata;
  logic [mem_fabric_pkg::StrbWidth-1:0]  ad_strb;
  logic [mem_fabric_pkg::IdWidth-1:0]    ad_id;

  // Access to response sender
  logic                                 ta_valid;
  logic                                 ta_ready;
  logic [mem_fabric_pkg::IdWidth-1:0]   ta_id;
  logic [mem_fabric_pkg::DataWidth-1:0] ta_rdata;
  logic                                 ta_err;

  req_buffer i_req_buffer (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_strb_i   ( req_strb_i   ),
    .req_id_i     ( req_id_i     ),
    .req_credit_o ( req_credit_o ),
    .out_valid_o  ( rb_valid     ),
    .out_ready_i  ( rb_ready     ),
    .out_we_o     ( rb_we        ),
    .out_addr_o   ( rb_addr      ),
    .out_wdata_o  ( rb_wdata     ),
    .out_strb_o   ( rb_strb      ),
    .out_id_o     ( rb_id        )
  );

  addr_decode i_addr_decode (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .in_valid_i   ( rb_valid  ),
    .in_ready_o   ( rb_ready  ),
    .in_we_i      ( rb_we     ),
    .in_addr_i    ( rb_addr   ),
    .in_wdata_i   ( rb_wdata  ),
    .in_strb_i    ( rb_strb   ),
    .in_id_i      ( rb_id     ),
    .out_valid_o  ( ad_valid  ),
    .out_ready_i  ( ad_ready  ),
    .out_target_o ( ad_target ),
    .out_index_o  ( ad_index  ),
    .out_we_o     ( ad_we     ),
    .out_wdata_o  ( ad_wdata  ),
    .out_strb_o   ( ad_strb   ),
    .out_id_o     ( ad_id     )
  );

  target_access i_target_access (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .in_valid_i  ( ad_valid  ),
    .in_ready_o  ( ad_ready  ),
    .in_target_i ( ad_target ),
    .in_index_i  ( ad_index  ),
    .in_we_i     ( ad_we     ),
    .in_wdata_i  ( ad_wdata  ),
    .in_strb_i   ( ad_strb   ),
    .in_id_i     ( ad_id     ),
    .out_valid_o ( ta_valid  ),
    .out_ready_i ( ta_ready  ),
    .out_id_o    ( ta_id     ),
    .out_rdata_o ( ta_rdata  ),
    .out_err_o   ( ta_err    )
  );

  rsp_sender i_rsp_sender (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .in_valid_i   ( ta_valid     ),
    .in_ready_o   ( ta_ready     ),
    .in_id_i      ( ta_id        ),
    .in_rdata_i   ( ta_rdata     ),
    .in_err_i     ( ta_err       ),
    .rsp_credit_i ( rsp_credit_i ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_id_o     ( rsp_id_o     ),
    .rsp_rdata_o  ( rsp_rdata_o  ),
    .rsp_err_o    ( rsp_err_o    )
  );

endmodule

`default_nettype wire

// File: req_buffer.sv
// Entry FIFO for incoming requests
// Takes every request and returns one request credit per pop
`timescale 1ns/10ps
`default_nettype none

module req_buffer (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire                                 req_valid_i,
  input  wire                                 req_we_i,
  input  wire mem_fabric_pkg::addr_u          req_addr_i,
  input  wire [mem_fabric_pkg::DataWidth-1:0] req_wdata_i,
  input  wire [mem_fabric_pkg::StrbWidth-1:0] req_strb_i,
  input  wire [mem_fabric_pkg::IdWidth-1:0]   req_id_i,
  output logic                                req_credit_o,
  output logic                                out_valid_o,
  input  wire                                 out_ready_i,
  output logic                                out_we_o,
  output mem_fabric_pkg::addr_u               out_addr_o,
  output logic [mem_fabric_pkg::DataWidth-1:0] out_wdata_o,
  output logic [mem_fabric_pkg::StrbWidth-1:0] out_strb_o,
  output logic [mem_fabric_pkg::IdWidth-1:0]   out_id_o
);

  // Storage
  logic                                we_mem    [mem_fabric_pkg::ReqCredits];
  mem_fabric_pkg::addr_u               addr_mem  [mem_fabric_pkg::ReqCredits];
  logic [mem_fabric_pkg::DataWidth-1:0] wdata_mem [mem_fabric_pkg::ReqCredits];
  logic [mem_fabric_pkg::StrbWidth-1:0] strb_mem  [mem_fabric_pkg::ReqCredits];
  logic [mem_fabric_pkg::IdWidth-1:0]   id_mem    [mem_fabric_pkg::ReqCredits];

  logic [mem_fabric_pkg::ReqPtrWidth-1:0] wr_ptr_q;
  logic [mem_fabric_pkg::ReqPtrWidth-1:0] rd_ptr_q;
  logic [mem_fabric_pkg::ReqCntWidth-1:0] count_q;
  logic                                   push;
  logic                                   pop;

  // The requester only sends while it holds a credit, so no full check
  assign push = req_valid_i;
  assign pop  = out_valid_o && out_ready_i;

  assign out_valid_o  = (count_q != '0);
  assign req_credit_o = pop;

  // Head of the FIFO
  assign out_we_o    = we_mem[rd_ptr_q];
  assign out_addr_o  = addr_mem[rd_ptr_q];
  assign out_wdata_o = wdata_mem[rd_ptr_q];
  assign out_strb_o  = strb_mem[rd_ptr_q];
  assign out_id_o    = id_mem[rd_ptr_q];

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      we_mem[wr_ptr_q]    <= req_we_i;
      addr_mem[wr_ptr_q]  <= req_addr_i;
      wdata_mem[wr_ptr_q] <= req_wdata_i;
      strb_mem[wr_ptr_q]  <= req_strb_i;
      id_mem[wr_ptr_q]    <= req_id_i;
    end
  end

endmodule

`default_nettype wire

// File: rsp_sender.sv
// Response FIFO and response credit counter
// Sends one response per cycle while credits remain
`timescale 1ns/10ps
`default_nettype none

module rsp_sender (
  input  wire                                  clk_i,
  input  wire                                  rst_ni,
  input  wire                                  in_valid_i,
  output logic                                 in_ready_o,
  input  wire [mem_fabric_pkg::IdWidth-1:0]    in_id_i,
  input  wire [mem_fabric_pkg::DataWidth-1:0]  in_rdata_i,
  input  wire                                  in_err_i,
  input  wire                                  rsp_credit_i,
  output logic                                 rsp_valid_o,
  output logic [mem_fabric_pkg::IdWidth-1:0]   rsp_id_o,
  output logic [mem_fabric_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                                 rsp_err_o
);

  logic [mem_fabric_pkg::IdWidth-1:0]   id_mem    [mem_fabric_pkg::RspDepth];
  logic [mem_fabric_pkg::DataWidth-1:0] rdata_mem [mem_fabric_pkg::RspDepth];
  logic                                 err_mem   [mem_fabric_pkg::RspDepth];

  logic [mem_fabric_pkg::RspPtrWidth-1:0] wr_ptr_q;
  logic [mem_fabric_pkg::RspPtrWidth-1:0] rd_ptr_q;
  logic [mem_fabric_pkg::RspCntWidth-1:0] count_q;
  logic [mem_fabric_pkg::CreditWidth-1:0] credit_q;
  logic                                   push;
  logic                                   send;

  assign in_ready_o = (count_q != mem_fabric_pkg::RspDepth[mem_fabric_pkg::RspCntWidth-1:0]);
  assign push       = in_valid_i && in_ready_o;
  assign send       = (count_q != '0) && (credit_q != '0);

  assign rsp_valid_o = send;
  assign rsp_id_o    = id_mem[rd_ptr_q];
  assign rsp_rdata_o = rdata_mem[rd_ptr_q];
  assign rsp_err_o   = err_mem[rd_ptr_q];

  // ----------------------------------------------------------------------
  // FIFO control and credit counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= mem_fabric_pkg::RspCredits[mem_fabric_pkg::CreditWidth-1:0];
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (send) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !send) begin
        count_q <= count_q + 1'b1;
      end else if (send && !push) begin
        count_q <= count_q - 1'b1;
      end
      // One credit spent per send, one back per pulse
      if (send && !rsp_credit_i) begin
        credit_q <= credit_q - 1'b1;
      end else if (rsp_credit_i && !send) begin
        credit_q <= credit_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q]    <= in_id_i;
      rdata_mem[wr_ptr_q] <= in_rdata_i;
      err_mem[wr_ptr_q]   <= in_err_i;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the memory fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_fabric \
  -f build.f -o sim_mem_fabric > sim.log 2>&1 \
  && ./obj_dir/sim_mem_fabric >> sim.log 2>&1 \
  || echo "Something failed" >> sim.log
if grep -q "Something failed" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
echo "Simulation passed"

// File: target_access.sv
// Target access stage
// Boot ROM table, byte-enabled SRAM array and response forming
`timescale 1ns/10ps
`default_nettype none

module target_access (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  input  wire                                   in_valid_i,
  output logic                                  in_ready_o,
  input  wire mem_fabric_pkg::target_e          in_target_i,
  input  wire [mem_fabric_pkg::IndexWidth-1:0]  in_index_i,
  input  wire                                   in_we_i,
  input  wire [mem_fabric_pkg::DataWidth-1:0]   in_wdata_i,
  input  wire [mem_fabric_pkg::StrbWidth-1:0]   in_strb_i,
  input  wire [mem_fabric_pkg::IdWidth-1:0]     in_id_i,
  output logic                                  out_valid_o,
  input  wire                                   out_ready_i,
  output logic [mem_fabric_pkg::IdWidth-1:0]    out_id_o,
  output logic [mem_fabric_pkg::DataWidth-1:0]  out_rdata_o,
  output logic                                  out_err_o
);

  logic [mem_fabric_pkg::DataWidth-1:0] rom    [mem_fabric_pkg::RomWords];
  logic [mem_fabric_pkg::DataWidth-1:0] sram_q [mem_fabric_pkg::SramWords];
  logic [mem_fabric_pkg::DataWidth-1:0] rd_data;
  logic                                 fire;

  assign in_ready_o = !out_valid_o || out_ready_i;
  assign fire       = in_valid_i && in_ready_o;

  // ----------------------------------------------------------------------
  // Boot ROM contents
  // ----------------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < mem_fabric_pkg::RomWords; k++) begin
      rom[k] = mem_fabric_pkg::RomPattern + k;
    end
  end

  // Writes and errors answer with zero data
  always_comb begin
    rd_data = '0;
    if (!in_we_i) begin
      if (in_target_i == mem_fabric_pkg::TgtRom) begin
        rd_data = rom[in_index_i[mem_fabric_pkg::RomIdxWidth-1:0]];
      end else if (in_target_i == mem_fabric_pkg::TgtSram) begin
        rd_data = sram_q[in_index_i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  // ----------------------------------------------------------------------
  // SRAM access and response register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (fire) begin
      if (in_we_i && (in_target_i == mem_fabric_pkg::TgtSram)) begin
        for (int b = 0; b < mem_fabric_pkg::StrbWidth; b++) begin
          if (in_strb_i[b]) begin
            sram_q[in_index_i][b*8 +: 8] <= in_wdata_i[b*8 +: 8];
          end
        end
      end
      out_id_o    <= in_id_i;
      out_rdata_o <= rd_data;
      out_err_o   <= (in_target_i == mem_fabric_pkg::TgtErr);
    end
  end

endmodule

`default_nettype wire

// File: tb_mem_fabric.sv
// Testbench for the memory fabric
// Clock and reset, stimulus table, request and response credit models,
// in-order response checker with timeouts
`timescale 1ns/10ps
`default_nettype none

module tb_mem_fabric;

  localparam int RowMax    = 32;
  localparam int Timeout   = 200;
  localparam int OpenRows  = 13;
  localparam int StallWait = 40;

  logic                                 clk_i = 1'b0;
  logic                                 rst_ni;
  logic                                 req_valid_i;
  logic                                 req_we_i;
  logic [mem_fabric_pkg::AddrWidth-1:0] req_addr_i;
  logic [mem_fabric_pkg::DataWidth-1:0] req_wdata_i;
  logic [mem_fabric_pkg::StrbWidth-1:0] req_strb_i;
  logic [mem_fabric_pkg::IdWidth-1:0]   req_id_i;
  logic                                 req_credit_o;
  logic                                 rsp_credit_i = 1'b0;
  logic                                 rsp_valid_o;
  logic [mem_fabric_pkg::IdWidth-1:0]   rsp_id_o;
  logic [mem_fabric_pkg::DataWidth-1:0] rsp_rdata_o;
  logic                                 rsp_err_o;

  // Stimulus table, one row per request and its expected response
  string       row_name  [RowMax];
  logic        row_we    [RowMax];
  logic [31:0] row_addr  [RowMax];
  logic [63:0] row_wdata [RowMax];
  logic [7:0]  row_strb  [RowMax];
  logic [3:0]  row_id    [RowMax];
  logic [63:0] row_rdata [RowMax];
  logic        row_err   [RowMax];
  int          num_rows = 0;

  int     sent          = 0;
  int     credits_back  = 0;
  int     rsp_seen      = 0;
  int     credits_given = 0;
  logic   withhold      = 1'b0;
  integer seed          = 73;

  always #20 clk_i = ~clk_i;

  mem_fabric_top mem_fabric_top_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_strb_i   ( req_strb_i   ),
    .req_id_i     ( req_id_i     ),
    .req_credit_o ( req_credit_o ),
    .rsp_credit_i ( rsp_credit_i ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_id_o     ( rsp_id_o     ),
    .rsp_rdata_o  ( rsp_rdata_o  ),
    .rsp_err_o    ( rsp_err_o    )
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] word_addr(input logic [15:0] tag, input int index);
    word_addr = {tag, index[12:0], 3'b000};
  endfunction

  task automatic add_row(input string name, input logic we, input logic [31:0] addr,
                         input logic [63:0] wdata, input logic [7:0] strb,
                         input logic [3:0] id, input logic [63:0] rdata, input logic err);
    row_name[num_rows]  = name;
    row_we[num_rows]    = we;
    row_addr[num_rows]  = addr;
    row_wdata[num_rows] = wdata;
    row_strb[num_rows]  = strb;
    row_id[num_rows]    = id;
    row_rdata[num_rows] = rdata;
    row_err[num_rows]   = err;
    num_rows++;
  endtask

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------
  task automatic build_table();
    logic [15:0] rom;
    logic [15:0] sram;
    logic [63:0] pat;
    rom  = mem_fabric_pkg::RomBase;
    sram = mem_fabric_pkg::SramBase;
    pat  = mem_fabric_pkg::RomPattern;
    add_row("rom_rd_0", 0, word_addr(rom, 0), 64'd0, 8'hFF, 4'h0, pat + 64'd0, 0);
    add_row("rom_rd_7", 0, word_addr(rom, 7), 64'd0, 8'hFF, 4'h1, pat + 64'd7, 0);
    add_row("rom_rd_31", 0, word_addr(rom, 31), 64'd0, 8'hFF, 4'h2, pat + 64'd31, 0);
    add_row("sram_wr_full", 1, word_addr(sram, 3), 64'h0123_4567_89AB_CDEF, 8'hFF, 4'h3,
            64'd0, 0);
    add_row("sram_rd_full", 0, word_addr(sram, 3), 64'd0, 8'hFF, 4'h4,
            64'h0123_4567_89AB_CDEF, 0);
    add_row("sram_wr_old", 1, word_addr(sram, 5), 64'h1122_3344_5566_7788, 8'hFF, 4'h5,
            64'd0, 0);
    // Only the low four byte lanes take the new data
    add_row("sram_wr_part", 1, word_addr(sram, 5), 64'hCAFE_F00D_DEAD_BEEF, 8'h0F, 4'h6,
            64'd0, 0);
    add_row("sram_rd_part", 0, word_addr(sram, 5), 64'd0, 8'hFF, 4'h7,
            64'h1122_3344_DEAD_BEEF, 0);
    add_row("err_unmapped", 0, word_addr(16'h0005, 0), 64'd0, 8'hFF, 4'h8, 64'd0, 1);
    add_row("err_gpio", 0, word_addr(mem_fabric_pkg::GpioBase, 1), 64'd0, 8'hFF, 4'h9,
            64'd0, 1);
    add_row("err_sram_range", 0, word_addr(sram, 600), 64'd0, 8'hFF, 4'hA, 64'd0, 1);
    add_row("err_rom_write", 1, word_addr(rom, 2), {64{1'b1}}, 8'hFF, 4'hB, 64'd0, 1);
    add_row("rom_rd_2_after", 0, word_addr(rom, 2), 64'd0, 8'hFF, 4'hC, pat + 64'd2, 0);
    // Back-to-back burst while response credits are held back,
    // long enough to back up every stage into a full entry FIFO
    for (int k = 13; k < 25; k++) begin
      add_row($sformatf("burst_rom_%0d", k), 0, word_addr(rom, k), 64'd0, 8'hFF, k[3:0],
              pat + 64'(k), 0);
    end
  endtask

  // Issue one row once a request credit is available
  task automatic issue_row(input int r);
    int waited;
    waited = 0;
    while ((mem_fabric_pkg::ReqCredits + credits_back - sent) <= 0) begin
      req_valid_i = 1'b0;
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        abort_run("Timeout: no request credit came back");
      end
    end
    req_valid_i = 1'b1;
    req_we_i    = row_we[r];
    req_addr_i  = row_addr[r];
    req_wdata_i = row_wdata[r];
    req_strb_i  = row_strb[r];
    req_id_i    = row_id[r];
    sent++;
    @(negedge clk_i);
  endtask

  task automatic wait_responses(input int target);
    int waited;
    waited = 0;
    while (rsp_seen < target) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        abort_run($sformatf("Timeout: only %0d of %0d responses arrived", rsp_seen, target));
      end
    end
  endtask

  task automatic wait_rsp_credits_back();
    int waited;
    waited = 0;
    while (credits_given != rsp_seen) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        abort_run("Timeout: response credits were not all returned");
      end
    end
  endtask

  task automatic wait_req_credits_back();
    int waited;
    waited = 0;
    while (credits_back != sent) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        abort_run("Timeout: request credits were not all returned");
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Monitors on the rising edge, credit returns on the falling edge
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni && req_credit_o) begin
      credits_back++;
      check_value("request credit balance", 64'd1, {63'd0, credits_back <= sent});
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && rsp_valid_o) begin
      if (rsp_seen >= num_rows) begin
        abort_run("A response arrived with no request outstanding");
      end
      check_value({row_name[rsp_seen], " id"}, 64'(row_id[rsp_seen]), 64'(rsp_id_o));
      check_value({row_name[rsp_seen], " data"}, row_rdata[rsp_seen], rsp_rdata_o);
      check_value({row_name[rsp_seen], " err"}, 64'(row_err[rsp_seen]), 64'(rsp_err_o));
      rsp_seen++;
    end
  end

  // Receiver hands back one credit per consumed response, with random gaps
  always @(negedge clk_i) begin
    rsp_credit_i = 1'b0;
    if (rst_ni && !withhold && (rsp_seen > credits_given) && (($random(seed) & 1) == 1)) begin
      rsp_credit_i = 1'b1;
      credits_given++;
    end
  end

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    req_id_i    = '0;
    build_table();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    for (int r = 0; r < OpenRows; r++) begin
      issue_row(r);
    end
    req_valid_i = 1'b0;
    wait_responses(OpenRows);
    wait_rsp_credits_back();

    // Hold back response credits so the pipeline backs up
    @(posedge clk_i);
    withhold = 1'b1;
    @(negedge clk_i);
    for (int r = OpenRows; r < num_rows; r++) begin
      issue_row(r);
    end
    req_valid_i = 1'b0;
    wait_responses(OpenRows + mem_fabric_pkg::RspCredits);
    repeat (StallWait) @(negedge clk_i);
    check_value("responses while credits withheld",
                64'(OpenRows + mem_fabric_pkg::RspCredits), 64'(rsp_seen));

    @(posedge clk_i);
    withhold = 1'b0;
    wait_responses(num_rows);
    wait_req_credits_back();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_mem_fabric_sva.sv
// Response credit assertions
// Port-level credit model, bound into the response sender
`timescale 1ns/10ps
`default_nettype none

module tb_mem_fabric_sva (
  input wire                                       clk_i,
  input wire                                       rst_ni,
  input wire                                       rsp_valid_i,
  input wire                                       rsp_credit_i,
  input wire [mem_fabric_pkg::CreditWidth-1:0]     credit_cnt_i
);

  // Credits the sender may still spend, seen from its ports
  logic [mem_fabric_pkg::CreditWidth-1:0] avail_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      avail_q <= mem_fabric_pkg::RspCredits[mem_fabric_pkg::CreditWidth-1:0];
    end else if (rsp_valid_i && !rsp_credit_i) begin
      avail_q <= avail_q - 1'b1;
    end else if (rsp_credit_i && !rsp_valid_i) begin
      avail_q <= avail_q + 1'b1;
    end
  end

  // No response goes out without a credit
  valid_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> (avail_q != '0))
    else $error("response sent with zero credits");

  // Receiver never returns more than it was given
  credit_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_cnt_i <= mem_fabric_pkg::RspCredits)
    else $error("response credit count above its initial value");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !rsp_valid_i)
    else $error("response valid high during reset");

endmodule

bind rsp_sender tb_mem_fabric_sva i_rsp_sender_sva (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .rsp_valid_i  ( rsp_valid_o  ),
  .rsp_credit_i ( rsp_credit_i ),
  .credit_cnt_i ( credit_q     )
);

`default_nettype wire
